// ==== verilog/dcache_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the data cache control pipeline
// Widths, request opcode and stage 1 outcome enums, request, lookup status
// and performance counter structs
////////////////////////////////////////////////////////////////////////////
package dcache_ctrl_pkg;

    // Request tag returned to the core
    localparam int TAG_W = 4;
    // Width of one performance counter
    localparam int CNT_W = 16;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } req_op_e;

    // One request as it moves down the pipeline
    typedef struct packed {
        req_op_e            op;
        logic               uncacheable;
        logic               need_rsp;
        logic [TAG_W-1:0]   tag;
    } dcache_req_t;

    // Directory, MSHR and write buffer status for the stage 1 request
    typedef struct packed {
        logic dir_hit;
        logic mshr_hit;
        logic mshr_full;
        logic mshr_alloc_ready;
        logic wbuf_write_ready;
    } lookup_t;

    // Single outcome of a stage 1 request
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_LOAD_HIT,
        ACT_LOAD_MISS,
        ACT_STORE_HIT,
        ACT_STORE_MISS,
        ACT_UNCACHED,
        ACT_HOLD
    } st1_action_e;

    typedef struct packed {
        logic [CNT_W-1:0] read_hit;
        logic [CNT_W-1:0] read_miss;
        logic [CNT_W-1:0] write_hit;
        logic [CNT_W-1:0] write_miss;
        logic [CNT_W-1:0] uncached;
        logic [CNT_W-1:0] hold;
    } perf_cnt_t;

endpackage

// ==== verilog/dcache_req_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Fixed priority request arbiter for stage 0
// Refill first, then replay table, then core
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_req_arbiter import dcache_ctrl_pkg::*; (
    input  logic        core_req_valid_i,
    input  logic        rtab_req_valid_i,
    input  logic        refill_req_valid_i,
    input  dcache_req_t core_req_i,
    input  dcache_req_t rtab_req_i,
    input  logic        rtab_full_i,
    input  logic        uc_busy_i,
    input  logic        st1_valid_i,
    input  logic        st2_valid_i,
    input  logic        bubble_i,
    output logic        core_req_ready_o,
    output logic        rtab_req_ready_o,
    output logic        refill_req_ready_o,
    output logic        st0_valid_o,
    output logic        st0_from_rtab_o,
    output dcache_req_t st0_req_o
);

    // Refill owns the cache arrays, so wait for an empty pipeline
    assign refill_req_ready_o = refill_req_valid_i & ~st1_valid_i & ~st2_valid_i;

    // Replay loses only to refill and to bubble cycles
    assign rtab_req_ready_o = rtab_req_valid_i & ~refill_req_valid_i & ~bubble_i;

    // Core is lowest priority
    // A full replay table would leave no room to hold a new core request
    assign core_req_ready_o = core_req_valid_i
                              & ~rtab_req_valid_i
                              & ~refill_req_valid_i
                              & ~rtab_full_i
                              & ~uc_busy_i
                              & ~bubble_i;

    // Refill carries no payload and does not enter stage 1
    assign st0_valid_o     = core_req_ready_o | rtab_req_ready_o;
    assign st0_from_rtab_o = rtab_req_ready_o;

    // Payload follows the presented source, independent of the grant
    assign st0_req_o = rtab_req_valid_i ? rtab_req_i : core_req_i;

    // Grants are exclusive across all three sources
    always_comb begin
        assert ($onehot0({core_req_ready_o, rtab_req_ready_o, refill_req_ready_o}))
            else $error("More than one request source granted");
    end

endmodule

// ==== verilog/dcache_ctrl_pe.sv ====
////////////////////////////////////////////////////////////////////////////
// Control engine for stage 1 and stage 2
// Stage 1 outcome, replay table signalling, MSHR allocation and
// pipeline bubble generation
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_ctrl_pe import dcache_ctrl_pkg::*; (
    input  logic              st1_valid_i,
    input  logic              st1_from_rtab_i,
    input  dcache_req_t       st1_req_i,
    input  logic              st2_valid_i,
    input  dcache_req_t       st2_req_i,
    input  lookup_t           lookup_i,
    input  logic              st0_is_load_i,
    input  logic              st0_valid_i,
    input  logic              rtab_req_valid_i,
    output logic              rsp_valid_o,
    output logic [TAG_W-1:0]  rsp_tag_o,
    output logic              uc_req_valid_o,
    output dcache_req_t       uc_req_o,
    output logic              wbuf_write_valid_o,
    output logic [TAG_W-1:0]  wbuf_write_tag_o,
    output logic              rtab_alloc_o,
    output logic              rtab_rback_o,
    output logic              rtab_commit_o,
    output dcache_req_t       rtab_alloc_req_o,
    output logic              mshr_alloc_o,
    output logic [TAG_W-1:0]  mshr_alloc_tag_o,
    output logic              st2_load_o,
    output logic              bubble_o,
    output st1_action_e       action_o
);

    logic st1_hold;
    logic st1_store;
    logic store_hold;

    // Cacheable store sitting in stage 1
    assign st1_store = st1_valid_i & ~st1_req_i.uncacheable & (st1_req_i.op == OP_STORE);

    // Store must wait for a pending refill on the line or for a write buffer slot
    assign store_hold = ~lookup_i.wbuf_write_ready | (~lookup_i.dir_hit & lookup_i.mshr_hit);

    always_comb begin
        action_o           = ACT_NONE;
        rsp_valid_o        = 1'b0;
        uc_req_valid_o     = 1'b0;
        wbuf_write_valid_o = 1'b0;
        st2_load_o         = 1'b0;

        if (st1_valid_i) begin
            if (st1_req_i.uncacheable) begin
                // Handed off whole, the handler answers the core itself
                uc_req_valid_o = 1'b1;
                action_o       = ACT_UNCACHED;
            end else if (st1_req_i.op == OP_LOAD) begin
                if (lookup_i.dir_hit) begin
                    action_o    = ACT_LOAD_HIT;
                    rsp_valid_o = st1_req_i.need_rsp;
                end else if (lookup_i.mshr_hit || lookup_i.mshr_full ||
                             !lookup_i.mshr_alloc_ready || st2_valid_i) begin
                    // Same line pending, no free MSHR, or MSHR port busy with stage 2
                    action_o = ACT_HOLD;
                end else begin
                    // Forward to stage 2 for MSHR allocation
                    action_o   = ACT_LOAD_MISS;
                    st2_load_o = 1'b1;
                end
            end else begin
                // No write while a read on the line is outstanding
                wbuf_write_valid_o = ~lookup_i.mshr_hit & lookup_i.wbuf_write_ready;
                if (store_hold) begin
                    action_o = ACT_HOLD;
                end else begin
                    action_o    = lookup_i.dir_hit ? ACT_STORE_HIT : ACT_STORE_MISS;
                    rsp_valid_o = st1_req_i.need_rsp;
                end
            end
        end
    end

    assign st1_hold = (action_o == ACT_HOLD);

    // New hold allocates, a replayed hold rolls back, anything else from replay commits
    assign rtab_alloc_o     = st1_hold & ~st1_from_rtab_i;
    assign rtab_rback_o     = st1_hold &  st1_from_rtab_i;
    assign rtab_commit_o    = st1_valid_i & st1_from_rtab_i & ~st1_hold;
    assign rtab_alloc_req_o = st1_req_i;

    // Payload fields all come straight from stage 1
    assign rsp_tag_o        = st1_req_i.tag;
    assign uc_req_o         = st1_req_i;
    assign wbuf_write_tag_o = st1_req_i.tag;

    // Stage 2 only ever allocates an MSHR entry
    assign mshr_alloc_o     = st2_valid_i;
    assign mshr_alloc_tag_o = st2_req_i.tag;

    // Bubble sources
    // MSHR hazard after allocation, hold or uncached, store then load on the
    // data RAM, and a finished replay with nothing else waiting in the table
    assign bubble_o = st2_valid_i
                      | st1_hold
                      | (action_o == ACT_UNCACHED)
                      | (st1_store & st0_valid_i & st0_is_load_i)
                      | (st1_valid_i & st1_from_rtab_i & ~rtab_req_valid_i);

    // A request either answers the core or goes to the replay table
    always_comb begin
        assert (!(rsp_valid_o && (rtab_alloc_o || rtab_rback_o)))
            else $error("Response issued together with a hold");
    end

endmodule

// ==== verilog/dcache_pipe_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Stage 1 and stage 2 request registers
// Valid bits are reset, payloads are not
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_pipe_regs import dcache_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        st0_valid_i,
    input  logic        st0_from_rtab_i,
    input  dcache_req_t st0_req_i,
    input  logic        st2_load_i,
    output logic        st1_valid_o,
    output logic        st1_from_rtab_o,
    output dcache_req_t st1_req_o,
    output logic        st2_valid_o,
    output dcache_req_t st2_req_o
);

    // Stage 1 never stalls, so it takes stage 0 on every edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st1_valid_o     <= 1'b0;
            st1_from_rtab_o <= 1'b0;
        end else begin
            st1_valid_o     <= st0_valid_i;
            st1_from_rtab_o <= st0_from_rtab_i;
        end
    end

    always_ff @(posedge clk_i) begin
        st1_req_o <= st0_req_i;
    end

    // Stage 2 lives for one cycle unless reloaded
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st2_valid_o <= 1'b0;
        end else begin
            st2_valid_o <= st2_load_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (st2_load_i) begin
            st2_req_o <= st1_req_o;
        end
    end

    // Stage 2 is never overwritten while it still allocates
    assert property (@(posedge clk_i) disable iff (!rst_n_i) st2_load_i |-> !st2_valid_o)
        else $error("Stage 2 reloaded while still valid");

endmodule

// ==== verilog/dcache_perf_counters.sv ====
////////////////////////////////////////////////////////////////////////////
// Saturating performance counters, one per stage 1 outcome
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_perf_counters import dcache_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  st1_action_e action_i,
    output perf_cnt_t   perf_o
);

    // Stick at all ones
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] val);
        logic [CNT_W-1:0] res;
        res = (&val) ? val : val + CNT_W'(1);
        return res;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            perf_o <= '0;
        end else begin
            // At most one outcome per cycle
            case (action_i)
                ACT_LOAD_HIT:   perf_o.read_hit   <= sat_inc(perf_o.read_hit);
                ACT_LOAD_MISS:  perf_o.read_miss  <= sat_inc(perf_o.read_miss);
                ACT_STORE_HIT:  perf_o.write_hit  <= sat_inc(perf_o.write_hit);
                ACT_STORE_MISS: perf_o.write_miss <= sat_inc(perf_o.write_miss);
                ACT_UNCACHED:   perf_o.uncached   <= sat_inc(perf_o.uncached);
                ACT_HOLD:       perf_o.hold       <= sat_inc(perf_o.hold);
                default: ;
            endcase
        end
    end

endmodule

// ==== verilog/dcache_ctrl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Data cache control pipeline top level
// Arbiter, pipeline registers, control engine and performance counters
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dcache_ctrl_top import dcache_ctrl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // Request sources
    input  logic              core_req_valid_i,
    output logic              core_req_ready_o,
    input  dcache_req_t       core_req_i,
    input  logic              rtab_req_valid_i,
    output logic              rtab_req_ready_o,
    input  dcache_req_t       rtab_req_i,
    input  logic              refill_req_valid_i,
    output logic              refill_req_ready_o,
    // Status from external blocks
    input  logic              rtab_full_i,
    input  logic              uc_busy_i,
    input  lookup_t           lookup_i,
    // Core response
    output logic              rsp_valid_o,
    output logic [TAG_W-1:0]  rsp_tag_o,
    // Uncached handler
    output logic              uc_req_valid_o,
    output dcache_req_t       uc_req_o,
    // Write buffer
    output logic              wbuf_write_valid_o,
    output logic [TAG_W-1:0]  wbuf_write_tag_o,
    // Replay table
    output logic              rtab_alloc_o,
    output logic              rtab_rback_o,
    output logic              rtab_commit_o,
    output dcache_req_t       rtab_alloc_req_o,
    // MSHR
    output logic              mshr_alloc_o,
    output logic [TAG_W-1:0]  mshr_alloc_tag_o,
    output perf_cnt_t         perf_o
);

    logic        st0_valid;
    logic        st0_from_rtab;
    dcache_req_t st0_req;
    logic        st1_valid;
    logic        st1_from_rtab;
    dcache_req_t st1_req;
    logic        st2_valid;
    dcache_req_t st2_req;
    logic        st2_load;
    logic        bubble;
    st1_action_e action;

    dcache_req_arbiter dcache_req_arbiter_inst (
        .core_req_valid_i   (core_req_valid_i),
        .rtab_req_valid_i   (rtab_req_valid_i),
        .refill_req_valid_i (refill_req_valid_i),
        .core_req_i         (core_req_i),
        .rtab_req_i         (rtab_req_i),
        .rtab_full_i        (rtab_full_i),
        .uc_busy_i          (uc_busy_i),
        .st1_valid_i        (st1_valid),
        .st2_valid_i        (st2_valid),
        .bubble_i           (bubble),
        .core_req_ready_o   (core_req_ready_o),
        .rtab_req_ready_o   (rtab_req_ready_o),
        .refill_req_ready_o (refill_req_ready_o),
        .st0_valid_o        (st0_valid),
        .st0_from_rtab_o    (st0_from_rtab),
        .st0_req_o          (st0_req)
    );

    dcache_pipe_regs dcache_pipe_regs_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .st0_valid_i     (st0_valid),
        .st0_from_rtab_i (st0_from_rtab),
        .st0_req_i       (st0_req),
        .st2_load_i      (st2_load),
        .st1_valid_o     (st1_valid),
        .st1_from_rtab_o (st1_from_rtab),
        .st1_req_o       (st1_req),
        .st2_valid_o     (st2_valid),
        .st2_req_o       (st2_req)
    );

    // Data RAM hazard looks at the presented request, not the grant,
    // since the grant itself depends on the bubble
    dcache_ctrl_pe dcache_ctrl_pe_inst (
        .st1_valid_i        (st1_valid),
        .st1_from_rtab_i    (st1_from_rtab),
        .st1_req_i          (st1_req),
        .st2_valid_i        (st2_valid),
        .st2_req_i          (st2_req),
        .lookup_i           (lookup_i),
        .st0_is_load_i      (st0_req.op == OP_LOAD),
        .st0_valid_i        (core_req_valid_i | rtab_req_valid_i),
        .rtab_req_valid_i   (rtab_req_valid_i),
        .rsp_valid_o        (rsp_valid_o),
        .rsp_tag_o          (rsp_tag_o),
        .uc_req_valid_o     (uc_req_valid_o),
        .uc_req_o           (uc_req_o),
        .wbuf_write_valid_o (wbuf_write_valid_o),
        .wbuf_write_tag_o   (wbuf_write_tag_o),
        .rtab_alloc_o       (rtab_alloc_o),
        .rtab_rback_o       (rtab_rback_o),
        .rtab_commit_o      (rtab_commit_o),
        .rtab_alloc_req_o   (rtab_alloc_req_o),
        .mshr_alloc_o       (mshr_alloc_o),
        .mshr_alloc_tag_o   (mshr_alloc_tag_o),
        .st2_load_o         (st2_load),
        .bubble_o           (bubble),
        .action_o           (action)
    );

    dcache_perf_counters dcache_perf_counters_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .action_i (action),
        .perf_o   (perf_o)
    );

endmodule

// ==== verification/tb_dcache_ctrl_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Directed test tasks for the data cache control testbench
// Request builder, expected stage 1 outcome, handshake and output checks,
// replay, blocking, refill, random and counter tests
////////////////////////////////////////////////////////////////////////////
`ifndef TB_DCACHE_CTRL_TASKS_SVH
`define TB_DCACHE_CTRL_TASKS_SVH

function automatic dcache_req_t make_req(input req_op_e op, input logic uc,
                                         input logic need, input logic [TAG_W-1:0] tag);
    dcache_req_t req;
    req.op          = op;
    req.uncacheable = uc;
    req.need_rsp    = need;
    req.tag         = tag;
    return req;
endfunction

// Outcome of one request under one lookup, from the decision rules
function automatic st1_action_e exp_action(input dcache_req_t req, input lookup_t lk);
    logic no_mshr;
    no_mshr = lk.mshr_hit | lk.mshr_full | ~lk.mshr_alloc_ready;
    if (req.uncacheable) begin
        return ACT_UNCACHED;
    end
    if (req.op == OP_LOAD) begin
        return lk.dir_hit ? ACT_LOAD_HIT : (no_mshr ? ACT_HOLD : ACT_LOAD_MISS);
    end
    // Stores wait for a write buffer slot, and on a miss to a pending line
    if (!lk.wbuf_write_ready || (!lk.dir_hit && lk.mshr_hit)) begin
        return ACT_HOLD;
    end
    return lk.dir_hit ? ACT_STORE_HIT : ACT_STORE_MISS;
endfunction

// Hold core valid until a ready seen at negedge, then drop it after the edge
task automatic wait_grant();
    logic granted;
    granted = 1'b0;
    while (!granted) begin
        @(negedge clk);
        granted = core_req_ready;
        @(posedge clk);
    end
    #1;
    core_req_valid = 1'b0;
endtask

// Stage 1 cycle, entered just after the accepting edge
task automatic check_st1(input dcache_req_t req, input logic from_rtab,
                         output st1_action_e act);
    logic hold;
    logic exp_rsp;
    logic exp_wbuf;
    act      = exp_action(req, lookup);
    hold     = (act == ACT_HOLD);
    exp_rsp  = req.need_rsp &
               (act == ACT_LOAD_HIT || act == ACT_STORE_HIT || act == ACT_STORE_MISS);
    exp_wbuf = ~req.uncacheable & (req.op == OP_STORE) &
               ~lookup.mshr_hit & lookup.wbuf_write_ready;
    exp_cnt[int'(act)]++;
    @(negedge clk);
    check_val("rsp_valid_o", 32'(rsp_valid), 32'(exp_rsp));
    if (exp_rsp) begin
        check_val("rsp_tag_o", 32'(rsp_tag), 32'(req.tag));
    end
    check_val("uc_req_valid_o", 32'(uc_req_valid), 32'(act == ACT_UNCACHED));
    if (act == ACT_UNCACHED) begin
        check_val("uc_req_o", 32'(uc_req), 32'(req));
    end
    check_val("wbuf_write_valid_o", 32'(wbuf_write_valid), 32'(exp_wbuf));
    if (exp_wbuf) begin
        check_val("wbuf_write_tag_o", 32'(wbuf_write_tag), 32'(req.tag));
    end
    check_val("rtab_alloc_o", 32'(rtab_alloc), 32'(hold & ~from_rtab));
    check_val("rtab_rback_o", 32'(rtab_rback), 32'(hold & from_rtab));
    check_val("rtab_commit_o", 32'(rtab_commit), 32'(~hold & from_rtab));
    if (hold) begin
        check_val("rtab_alloc_req_o", 32'(rtab_alloc_req), 32'(req));
    end
endtask

// Cycle after stage 1, MSHR allocation only for a forwarded miss
task automatic check_st2(input dcache_req_t req, input st1_action_e act);
    logic miss;
    miss = (act == ACT_LOAD_MISS);
    @(posedge clk);
    #1;
    // Core probe that the stage 2 bubble must refuse
    if (miss) begin
        core_req_valid = 1'b1;
    end
    @(negedge clk);
    check_val("mshr_alloc_o", 32'(mshr_alloc), 32'(miss));
    if (miss) begin
        check_val("mshr_alloc_tag_o", 32'(mshr_alloc_tag), 32'(req.tag));
        check_val("core_req_ready_o", 32'(core_req_ready), 32'h0);
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
    end
endtask

task automatic do_req(input dcache_req_t req, input lookup_t lk);
    st1_action_e act;
    @(posedge clk);
    #1;
    lookup         = lk;
    core_req       = req;
    core_req_valid = 1'b1;
    wait_grant();
    check_st1(req, 1'b0, act);
    check_st2(req, act);
endtask

// Oldest held request against an uncacheable core request
task automatic replay_round(input lookup_t lk);
    dcache_req_t held;
    dcache_req_t other;
    st1_action_e act;
    if (held_q.size() == 0) begin
        fail_run("Replay test found no held request in the replay table");
    end else begin
        held  = held_q[0];
        other = make_req(OP_LOAD, 1'b1, 1'b1, 4'hc);
        @(posedge clk);
        #1;
        lookup         = lk;
        rtab_req       = held;
        rtab_req_valid = 1'b1;
        core_req       = other;
        core_req_valid = 1'b1;
        @(negedge clk);
        check_val("rtab_req_ready_o", 32'(rtab_req_ready), 32'h1);
        check_val("core_req_ready_o", 32'(core_req_ready), 32'h0);
        @(posedge clk);
        #1;
        rtab_req_valid = 1'b0;
        check_st1(held, 1'b1, act);
        // Bubble after the replay keeps core out one more cycle
        check_val("core_req_ready_o", 32'(core_req_ready), 32'h0);
        wait_grant();
        check_st1(other, 1'b0, act);
        check_st2(other, act);
    end
endtask

task automatic check_blocked(input logic full, input logic busy);
    @(posedge clk);
    #1;
    lookup         = lookup_t'(5'b10011);
    core_req       = make_req(OP_LOAD, 1'b0, 1'b1, 4'hd);
    core_req_valid = 1'b1;
    rtab_full      = full;
    uc_busy        = busy;
    repeat (3) begin
        @(negedge clk);
        check_val("core_req_ready_o", 32'(core_req_ready), 32'h0);
    end
    @(posedge clk);
    #1;
    core_req_valid = 1'b0;
    rtab_full      = 1'b0;
    uc_busy        = 1'b0;
endtask

task automatic test_refill();
    dcache_req_t req;
    st1_action_e act;
    req = make_req(OP_LOAD, 1'b0, 1'b1, 4'he);
    @(posedge clk);
    #1;
    lookup           = lookup_t'(5'b00011);
    core_req         = req;
    core_req_valid   = 1'b1;
    refill_req_valid = 1'b1;
    // Empty pipeline, refill goes ahead of core
    @(negedge clk);
    check_val("refill_req_ready_o", 32'(refill_req_ready), 32'h1);
    check_val("core_req_ready_o", 32'(core_req_ready), 32'h0);
    @(posedge clk);
    #1;
    refill_req_valid = 1'b0;
    wait_grant();
    // Forwarded miss occupies stage 1, then stage 2
    refill_req_valid = 1'b1;
    check_st1(req, 1'b0, act);
    check_val("refill_req_ready_o", 32'(refill_req_ready), 32'h0);
    @(negedge clk);
    check_val("mshr_alloc_o", 32'(mshr_alloc), 32'h1);
    check_val("refill_req_ready_o", 32'(refill_req_ready), 32'h0);
    @(negedge clk);
    check_val("refill_req_ready_o", 32'(refill_req_ready), 32'h1);
    @(posedge clk);
    #1;
    refill_req_valid = 1'b0;
endtask

// Random op, flags, tag and lookup, one request at a time
task automatic test_random(input int count);
    logic [31:0] r;
    repeat (count) begin
        r = $random(seed);
        do_req(make_req(req_op_e'(r[0]), r[1] & r[2], r[3], r[7:4]),
               lookup_t'(r[12:8]));
    end
endtask

task automatic check_counters();
    @(negedge clk);
    check_val("perf_o.read_hit", 32'(perf.read_hit), 32'(exp_cnt[int'(ACT_LOAD_HIT)]));
    check_val("perf_o.read_miss", 32'(perf.read_miss), 32'(exp_cnt[int'(ACT_LOAD_MISS)]));
    check_val("perf_o.write_hit", 32'(perf.write_hit), 32'(exp_cnt[int'(ACT_STORE_HIT)]));
    check_val("perf_o.write_miss", 32'(perf.write_miss),
              32'(exp_cnt[int'(ACT_STORE_MISS)]));
    check_val("perf_o.uncached", 32'(perf.uncached), 32'(exp_cnt[int'(ACT_UNCACHED)]));
    check_val("perf_o.hold", 32'(perf.hold), 32'(exp_cnt[int'(ACT_HOLD)]));
endtask

`endif

// ==== verification/tb_dcache_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top for the data cache control pipeline
// Clock, reset, DUT, replay table model, cycle limit, value check and
// the directed test sequence
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_dcache_ctrl import dcache_ctrl_pkg::*; ();

    // About 300 cycles of tests, with wide margin
    localparam int MAX_CYCLES = 2000;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             core_req_valid;
    logic             core_req_ready;
    dcache_req_t      core_req;
    logic             rtab_req_valid;
    logic             rtab_req_ready;
    dcache_req_t      rtab_req;
    logic             refill_req_valid;
    logic             refill_req_ready;
    logic             rtab_full;
    logic             uc_busy;
    lookup_t          lookup;
    logic             rsp_valid;
    logic [TAG_W-1:0] rsp_tag;
    logic             uc_req_valid;
    dcache_req_t      uc_req;
    logic             wbuf_write_valid;
    logic [TAG_W-1:0] wbuf_write_tag;
    logic             rtab_alloc;
    logic             rtab_rback;
    logic             rtab_commit;
    dcache_req_t      rtab_alloc_req;
    logic             mshr_alloc;
    logic [TAG_W-1:0] mshr_alloc_tag;
    perf_cnt_t        perf;

    // Replay table contents, oldest first
    dcache_req_t      held_q[$];
    // Expected counter values, indexed by stage 1 outcome
    int               exp_cnt[7];
    int               cycle_cnt = 0;
    integer           seed;

    always #50 clk = ~clk;

    dcache_ctrl_top dcache_ctrl_top_inst (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .core_req_valid_i   (core_req_valid),
        .core_req_ready_o   (core_req_ready),
        .core_req_i         (core_req),
        .rtab_req_valid_i   (rtab_req_valid),
        .rtab_req_ready_o   (rtab_req_ready),
        .rtab_req_i         (rtab_req),
        .refill_req_valid_i (refill_req_valid),
        .refill_req_ready_o (refill_req_ready),
        .rtab_full_i        (rtab_full),
        .uc_busy_i          (uc_busy),
        .lookup_i           (lookup),
        .rsp_valid_o        (rsp_valid),
        .rsp_tag_o          (rsp_tag),
        .uc_req_valid_o     (uc_req_valid),
        .uc_req_o           (uc_req),
        .wbuf_write_valid_o (wbuf_write_valid),
        .wbuf_write_tag_o   (wbuf_write_tag),
        .rtab_alloc_o       (rtab_alloc),
        .rtab_rback_o       (rtab_rback),
        .rtab_commit_o      (rtab_commit),
        .rtab_alloc_req_o   (rtab_alloc_req),
        .mshr_alloc_o       (mshr_alloc),
        .mshr_alloc_tag_o   (mshr_alloc_tag),
        .perf_o             (perf)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        assert (got === expected)
            else fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                    name, got, expected));
    endtask

    // Replay table model
    // Entries enter on alloc, leave on commit and stay across a rollback
    always @(negedge clk) begin
        if (rst_n && rtab_alloc) begin
            held_q.push_back(rtab_alloc_req);
        end
        if (rst_n && rtab_commit) begin
            if (held_q.size() == 0) begin
                fail_run("Replay table commit seen with no held request");
            end else begin
                held_q.delete(0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run("Run exceeded the cycle limit before the tests finished");
        end
    end

    `include "tb_dcache_ctrl_tasks.svh"

    initial begin
        rst_n            = 1'b0;
        core_req_valid   = 1'b0;
        core_req         = '0;
        rtab_req_valid   = 1'b0;
        rtab_req         = '0;
        refill_req_valid = 1'b0;
        rtab_full        = 1'b0;
        uc_busy          = 1'b0;
        lookup           = '0;
        seed             = 32'h64a1;
        foreach (exp_cnt[i]) begin
            exp_cnt[i] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Lookup bits: dir_hit, mshr_hit, mshr_full, mshr_alloc_ready, wbuf_write_ready
        // Load hit, forwarded miss, then the three ways a miss is held
        do_req(make_req(OP_LOAD, 1'b0, 1'b1, 4'h1), lookup_t'(5'b10011));
        do_req(make_req(OP_LOAD, 1'b0, 1'b1, 4'h2), lookup_t'(5'b00011));
        do_req(make_req(OP_LOAD, 1'b0, 1'b1, 4'h3), lookup_t'(5'b01011));
        do_req(make_req(OP_LOAD, 1'b0, 1'b1, 4'h4), lookup_t'(5'b00111));
        do_req(make_req(OP_LOAD, 1'b0, 1'b1, 4'h5), lookup_t'(5'b00001));

        // Oldest held load, first still missing, then hitting
        replay_round(lookup_t'(5'b01011));
        replay_round(lookup_t'(5'b10011));

        // Store hit, no write buffer slot, miss on a pending line
        do_req(make_req(OP_STORE, 1'b0, 1'b1, 4'h6), lookup_t'(5'b10011));
        do_req(make_req(OP_STORE, 1'b0, 1'b1, 4'h7), lookup_t'(5'b10010));
        do_req(make_req(OP_STORE, 1'b0, 1'b1, 4'h8), lookup_t'(5'b01011));

        // Uncacheable load goes to the uncached handler
        do_req(make_req(OP_LOAD, 1'b1, 1'b1, 4'h9), lookup_t'(5'b00011));
        check_blocked(1'b1, 1'b0);
        check_blocked(1'b0, 1'b1);
        test_refill();

        test_random(40);
        check_counters();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verification
verilog/dcache_ctrl_pkg.sv
verilog/dcache_req_arbiter.sv
verilog/dcache_ctrl_pe.sv
verilog/dcache_pipe_regs.sv
verilog/dcache_perf_counters.sv
verilog/dcache_ctrl_top.sv
verification/tb_dcache_ctrl.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the data cache control pipeline

VERILATOR ?= verilator
TOP       ?= tb_dcache_ctrl
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulation exit status is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
